/* filelist.f */
+incdir+include
hw/tlp_pkg.sv
hw/tlp_stream_if.sv
hw/tlp_packer.sv
hw/tlp_fifo.sv
hw/tlp_unpacker.sv
hw/intx_pacer.sv
hw/pcie_tlp_bridge.sv
verification/tb_pcie_tlp_bridge.sv

/* hw/intx_pacer.sv */
/*
 * Legacy interrupt pacer: requests, waits for the grant, then draws
 * from a Galois LFSR and holds a fixed time before the next request.
 */

`default_nettype none

`include "tlp_consts.svh"

module intx_pacer (
    input  wire logic   clk_sys,
    input  wire logic   rst,
    input  wire logic   int_rdy,
    output logic        int_assert
);

    // feedback on bits 1, 2, 3, 5 and 7 when bit 31 shifts out
    localparam logic [31:0] LFSR_TAPS = 32'h0000_00ae;
    localparam int          HOLD_W    = $clog2(`INT_HOLD_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_REQ,
        ST_DRAW,
        ST_HOLD
    } state_t;

    state_t             state;
    logic [31:0]        lfsr;
    logic [31:0]        lfsr_next;
    logic [HOLD_W-1:0]  hold_cnt;
    logic               int_q;

    assign lfsr_next  = {lfsr[30:0], lfsr[31]} ^ (lfsr[31] ? LFSR_TAPS : 32'h0);
    assign int_assert = int_q;

    // ------------------------------------------------------------------------
    // random source, seeded at reset only
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys)
    begin
        if (rst)
            lfsr <= `INT_LFSR_SEED;
        else if (state == ST_DRAW)
            lfsr <= lfsr_next;
    end

    // ------------------------------------------------------------------------
    // request / draw / hold
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys)
    begin
        if (rst)
        begin
            state    <= ST_REQ;
            int_q    <= 1'b0;
            hold_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_REQ:
                begin
                    int_q <= 1'b1;
                    // grant only counts once the request is visible
                    if (int_q && int_rdy)
                    begin
                        int_q <= 1'b0;
                        state <= ST_DRAW;
                    end
                end
                ST_DRAW:
                begin
                    if (lfsr > `INT_LFSR_THRESHOLD)
                    begin
                        hold_cnt <= '0;
                        state    <= ST_HOLD;
                    end
                end
                ST_HOLD:
                begin
                    if (hold_cnt == HOLD_W'(`INT_HOLD_CYCLES - 1))
                    begin
                        int_q <= 1'b1;
                        state <= ST_REQ;
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= ST_REQ;
                end
            endcase
        end
    end

    a_fall_on_grant : assert property (
        @(posedge clk_sys) disable iff (rst)
        $fell(int_assert) |-> $past(int_rdy)
    ) else $error("int_assert dropped without a grant");

endmodule

`default_nettype wire

/* hw/pcie_tlp_bridge.sv */
/*
 * Top level of the fabric-side TLP stream bridge: packer, wide word
 * buffer, unpacker and legacy interrupt pacer on clk_sys.
 */

`default_nettype none

`include "tlp_consts.svh"

module pcie_tlp_bridge
    import tlp_pkg::*;
(
    input  wire logic                                    clk_sys,
    input  wire logic                                    rst,

    // core receive beats
    input  wire logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]   rx_data,
    input  wire logic [`TLP_CORE_DWS*4-1:0]              rx_keep,
    input  wire logic                                    rx_last,
    input  wire logic                                    rx_valid,
    output logic                                         rx_ready,

    // core transmit beats
    output logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]        tx_data,
    output logic [`TLP_CORE_DWS*4-1:0]                   tx_keep,
    output logic                                         tx_last,
    output logic                                         tx_valid,
    input  wire logic                                    tx_ready,

    // legacy interrupt
    input  wire logic                                    int_rdy,
    output logic                                         int_assert
);

    tlp_stream_if #(.beat_t(beat128_t)) pack_s ();
    tlp_stream_if #(.beat_t(beat128_t)) wide_s ();

    tlp_packer i_tlp_packer (
        .clk_sys    ( clk_sys           ),
        .rst        ( rst               ),
        .rx_data    ( rx_data           ),
        .rx_keep    ( rx_keep           ),
        .rx_last    ( rx_last           ),
        .rx_valid   ( rx_valid          ),
        .rx_ready   ( rx_ready          ),
        .pack_s     ( pack_s.source     )
    );

    tlp_fifo #(.item_t(beat128_t)) i_tlp_fifo (
        .clk_sys    ( clk_sys           ),
        .rst        ( rst               ),
        .wr_s       ( pack_s.sink       ),
        .rd_s       ( wide_s.source     )
    );

    tlp_unpacker i_tlp_unpacker (
        .clk_sys    ( clk_sys           ),
        .rst        ( rst               ),
        .wide_s     ( wide_s.sink       ),
        .tx_data    ( tx_data           ),
        .tx_keep    ( tx_keep           ),
        .tx_last    ( tx_last           ),
        .tx_valid   ( tx_valid          ),
        .tx_ready   ( tx_ready          )
    );

    intx_pacer i_intx_pacer (
        .clk_sys    ( clk_sys           ),
        .rst        ( rst               ),
        .int_rdy    ( int_rdy           ),
        .int_assert ( int_assert        )
    );

endmodule

`default_nettype wire

/* hw/tlp_fifo.sv */
/*
 * Synchronous first-word-fall-through buffer of wide words.
 * Write side ready is a credit, high while two words are free.
 */

`default_nettype none

`include "tlp_consts.svh"

module tlp_fifo
    import tlp_pkg::*;
#(
    parameter type item_t = beat128_t
)
(
    input  wire logic   clk_sys,
    input  wire logic   rst,
    tlp_stream_if.sink   wr_s,
    tlp_stream_if.source rd_s
);

    localparam int DEPTH = `TLP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t              mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   fill;
    logic               do_wr;
    logic               do_rd;

    // the packer may finish one word after credit drops, so every valid writes
    assign do_wr = wr_s.valid;
    assign do_rd = rd_s.valid && rd_s.ready;

    assign wr_s.ready = fill <= CNT_W'(DEPTH - 2);
    assign rd_s.valid = fill != '0;
    assign rd_s.beat  = mem[rd_ptr];

    always_ff @(posedge clk_sys)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_s.beat;
        end
    end

    // ------------------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_sys)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    a_no_overflow : assert property (
        @(posedge clk_sys) disable iff (rst)
        !(do_wr && fill == CNT_W'(DEPTH))
    ) else $error("write into a full buffer");

    // an empty buffer has both pointers on the same slot
    a_no_underflow : assert property (
        @(posedge clk_sys) disable iff (rst)
        (fill == '0) |-> (rd_ptr == wr_ptr)
    ) else $error("read from an empty buffer");

endmodule

`default_nettype wire

/* hw/tlp_packer.sv */
/*
 * Receive side packer: gathers 64-bit core beats of one or two dwords
 * into 128-bit wide words of up to four dwords.
 */

`default_nettype none

`include "tlp_consts.svh"

module tlp_packer
    import tlp_pkg::*;
(
    input  wire logic                                    clk_sys,
    input  wire logic                                    rst,
    input  wire logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]   rx_data,
    input  wire logic [`TLP_CORE_DWS*4-1:0]              rx_keep,
    input  wire logic                                    rx_last,
    input  wire logic                                    rx_valid,
    output logic                                         rx_ready,
    tlp_stream_if.source                                 pack_s
);

    localparam int CNT_W = $clog2(`TLP_WIDE_DWS + 1);

    dw_t [`TLP_WIDE_DWS-1:0]    stage_dw;
    logic [CNT_W-1:0]           dw_cnt;
    logic                       last_q;
    logic                       take;
    logic                       word_out;
    logic [CNT_W-1:0]           base;
    logic [CNT_W-1:0]           cnt_next;
    beat128_t                   word;

    // ------------------------------------------------------------------------
    // staging word and dword count
    // ------------------------------------------------------------------------

    // the fifo credit is the core ready directly
    assign rx_ready = pack_s.ready;
    assign take     = rx_valid && rx_ready;

    // word leaves once past two dwords or when it closes a packet
    assign word_out = last_q || (dw_cnt > CNT_W'(`TLP_CORE_DWS));

    // a beat arriving with a word on its way out starts a fresh word
    assign base     = word_out ? '0 : dw_cnt;
    // keep bit 4 flags the upper dword of the beat
    assign cnt_next = base + CNT_W'(1) + CNT_W'(rx_keep[`TLP_DW_BITS/8]);

    always_ff @(posedge clk_sys)
    begin
        if (rst)
        begin
            dw_cnt <= '0;
            last_q <= 1'b0;
        end
        else if (take)
        begin
            dw_cnt <= cnt_next;
            last_q <= rx_last;
        end
        else if (word_out)
        begin
            dw_cnt <= '0;
            last_q <= 1'b0;
        end
    end

    // upper dword lands even for a one-dword beat, keepdw masks it
    always_ff @(posedge clk_sys)
    begin
        if (take)
        begin
            stage_dw[base +: `TLP_CORE_DWS] <= rx_data;
        end
    end

    // ------------------------------------------------------------------------
    // wide word out, presented for exactly one cycle
    // ------------------------------------------------------------------------

    assign word.data   = stage_dw;
    assign word.keepdw = {dw_cnt > CNT_W'(3), dw_cnt > CNT_W'(2), dw_cnt > CNT_W'(1), 1'b1};
    assign word.last   = last_q;

    assign pack_s.valid = word_out;
    assign pack_s.beat  = word;

    // credit low for two cycles means no beat could have completed a word
    a_credit_respected : assert property (
        @(posedge clk_sys) disable iff (rst)
        !(pack_s.valid && !pack_s.ready && !$past(pack_s.ready))
    ) else $error("packer emitted a word after two cycles without credit");

endmodule

`default_nettype wire

/* hw/tlp_pkg.sv */
/*
 * Dword, core beat and wide word types of the TLP stream bridge.
 */

`default_nettype none

`include "tlp_consts.svh"

package tlp_pkg;

    // one PCIe dword
    typedef logic [`TLP_DW_BITS-1:0] dw_t;

    // 64-bit core beat, byte keep as the core presents it
    typedef struct packed {
        dw_t [`TLP_CORE_DWS-1:0]       data;
        logic [`TLP_CORE_DWS*4-1:0]    keep;
        logic                          last;
    } beat64_t;

    // 128-bit wide word
    // keepdw has one bit per dword, always contiguous from bit 0
    typedef struct packed {
        dw_t [`TLP_WIDE_DWS-1:0]       data;
        logic [`TLP_WIDE_DWS-1:0]      keepdw;
        logic                          last;
    } beat128_t;

endpackage

`default_nettype wire

/* hw/tlp_stream_if.sv */
/*
 * Valid/ready stream interface, payload type set per instance.
 */

`default_nettype none

interface tlp_stream_if #(
    parameter type beat_t = logic
);

    logic   valid;
    logic   ready;
    beat_t  beat;

    // ------------------------------------------------------------------------
    // a transfer happens on an edge with valid and ready both high;
    // beat stays stable while valid is high and ready is low.
    // on the packer side ready is a credit: high while two words are free
    // ------------------------------------------------------------------------

    modport source (
        output valid,
        output beat,
        input  ready
    );

    modport sink (
        input  valid,
        input  beat,
        output ready
    );

endinterface

`default_nettype wire

/* hw/tlp_unpacker.sv */
/*
 * Transmit side unpacker: splits 128-bit wide words into one or two
 * 64-bit core beats, low dwords first.
 */

`default_nettype none

`include "tlp_consts.svh"

module tlp_unpacker
    import tlp_pkg::*;
(
    input  wire logic                                    clk_sys,
    input  wire logic                                    rst,
    tlp_stream_if.sink                                   wide_s,
    output logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]        tx_data,
    output logic [`TLP_CORE_DWS*4-1:0]                   tx_keep,
    output logic                                         tx_last,
    output logic                                         tx_valid,
    input  wire logic                                    tx_ready
);

    dw_t [`TLP_CORE_DWS-1:0]    hi_data;
    logic                       hi_two;
    logic                       hi_last;
    logic                       hi_pend;
    logic                       two_dw;
    logic                       wide_take;

    // ------------------------------------------------------------------------
    // first beat straight from the wide word, second from the upper half
    // ------------------------------------------------------------------------

    // word is popped with its first beat, upper half parked in hi_*
    assign wide_s.ready = tx_ready && !hi_pend;
    assign wide_take    = wide_s.valid && wide_s.ready;

    assign two_dw   = hi_pend ? hi_two : wide_s.beat.keepdw[1];
    assign tx_valid = hi_pend || wide_s.valid;
    assign tx_data  = hi_pend ? hi_data : wide_s.beat.data[`TLP_CORE_DWS-1:0];
    assign tx_keep  = two_dw ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
    // last moves to the second beat when one follows
    assign tx_last  = hi_pend ? hi_last : (wide_s.beat.last && !wide_s.beat.keepdw[2]);

    always_ff @(posedge clk_sys)
    begin
        if (rst)
        begin
            hi_pend <= 1'b0;
        end
        else if (wide_take)
        begin
            hi_pend <= wide_s.beat.keepdw[2];
        end
        else if (hi_pend && tx_ready)
        begin
            hi_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (wide_take)
        begin
            hi_data <= wide_s.beat.data[`TLP_WIDE_DWS-1:`TLP_CORE_DWS];
            hi_two  <= wide_s.beat.keepdw[3];
            hi_last <= wide_s.beat.last;
        end
    end

    a_keep_code : assert property (
        @(posedge clk_sys) disable iff (rst)
        tx_valid |-> (tx_keep == `TLP_KEEP_FULL || tx_keep == `TLP_KEEP_LOW)
    ) else $error("tx_keep is not a valid core keep code");

endmodule

`default_nettype wire

/* include/tlp_consts.svh */
/*
 * Widths, keep codes, buffer depth and interrupt pacer constants
 * shared by the TLP stream bridge.
 */

`ifndef TLP_CONSTS_SVH
`define TLP_CONSTS_SVH

// stream geometry
`define TLP_DW_BITS         32
`define TLP_CORE_DWS        2
`define TLP_WIDE_DWS        4

// core keep codes, two dwords or the low dword only
`define TLP_KEEP_FULL       8'hff
`define TLP_KEEP_LOW        8'h0f

// wide word buffer depth in words
`define TLP_FIFO_DEPTH      8

// legacy interrupt pacer
`define INT_LFSR_SEED       32'h097d_7840
// roughly 3/8 of the full 32-bit range
`define INT_LFSR_THRESHOLD  32'h6000_0000
`define INT_HOLD_CYCLES     64

`endif

/* verification/tb_pcie_tlp_bridge.sv */
/*
 * Testbench for the TLP stream bridge: random packets against a beat
 * model, tx back-pressure and stall, legacy interrupt pacing checks.
 */

`default_nettype none

`include "tlp_consts.svh"

module tb_pcie_tlp_bridge
    import tlp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 400;
    localparam int DRAIN_LIMIT = 3000;
    localparam int INT_LIMIT   = 4000;

    logic                                   clk_sys;
    logic                                   rst;
    logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]  rx_data;
    logic [`TLP_CORE_DWS*4-1:0]             rx_keep;
    logic                                   rx_last;
    logic                                   rx_valid;
    logic                                   rx_ready;
    logic [`TLP_CORE_DWS*`TLP_DW_BITS-1:0]  tx_data;
    logic [`TLP_CORE_DWS*4-1:0]             tx_keep;
    logic                                   tx_last;
    logic                                   tx_valid;
    logic                                   tx_ready;
    logic                                   int_rdy;
    logic                                   int_assert;

    integer                     seed;
    int                         err_cnt;
    int                         chk_cnt;
    int                         test_cnt;
    int                         test_err_base;
    bit                         aborted;
    int                         tx_mode;
    bit                         int_mode;

    // expected tx beats, built from accepted rx beats by the packing rule
    beat64_t                    exp_q[$];
    dw_t [`TLP_WIDE_DWS-1:0]    stg;
    int                         stg_cnt;
    beat64_t                    held;
    bit                         stall_q;
    bit                         saw_rx_stall;

    // interrupt model
    logic                       prev_int;
    logic                       prev_rdy;
    bit                         in_gap;
    int                         low_cnt;
    int                         grants;
    int                         gaps;

    pcie_tlp_bridge i_dut (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .rx_data    ( rx_data    ),
        .rx_keep    ( rx_keep    ),
        .rx_last    ( rx_last    ),
        .rx_valid   ( rx_valid   ),
        .rx_ready   ( rx_ready   ),
        .tx_data    ( tx_data    ),
        .tx_keep    ( tx_keep    ),
        .tx_last    ( tx_last    ),
        .tx_valid   ( tx_valid   ),
        .tx_ready   ( tx_ready   ),
        .int_rdy    ( int_rdy    ),
        .int_assert ( int_assert )
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // --------------------------------------------------------------------------
    // compare and report helpers
    // --------------------------------------------------------------------------

    task automatic check_beat(input string name, input beat64_t exp, input beat64_t act);
        chk_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp)
        begin
            err_cnt++;
            $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        err_cnt++;
        aborted = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s: %s, %0d errors", test_cnt, name,
                 (err_cnt == test_err_base) ? "ok" : "failed", err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // one wide word of n dwords becomes one or two core beats
    task automatic push_expected_beats(input dw_t [`TLP_WIDE_DWS-1:0] w, input int n,
                                       input bit last);
        beat64_t b;
        b.data[0] = w[0];
        b.data[1] = (n >= 2) ? w[1] : '0;
        b.keep    = (n >= 2) ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
        b.last    = last && (n <= 2);
        exp_q.push_back(b);
        if (n > 2)
        begin
            b.data[0] = w[2];
            b.data[1] = (n == 4) ? w[3] : '0;
            b.keep    = (n == 4) ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
            b.last    = last;
            exp_q.push_back(b);
        end
    endtask

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------

    // called at a rising edge, returns at the edge that takes the beat
    task automatic send_beat(input logic [63:0] d, input logic [7:0] k, input logic l);
        int n;
        rx_data  <= d;
        rx_keep  <= k;
        rx_last  <= l;
        rx_valid <= 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (!rx_ready && !aborted)
        begin
            @(negedge clk_sys);
            n++;
            if (n > WAIT_LIMIT)
                note_timeout("rx_ready stayed low");
        end
        @(posedge clk_sys);
    endtask

    // kmode 0 random keep, 1 one dword per beat, 2 two dwords per beat
    task automatic run_packets(input int count, input int kmode);
        logic [63:0] d;
        logic [7:0]  k;
        int          len;
        int          gap;
        for (int p = 0; p < count && !aborted; p++)
        begin
            len = 1 + $unsigned($random(seed)) % 12;
            for (int i = 0; i < len && !aborted; i++)
            begin
                d = {$random(seed), $random(seed)};
                case (kmode)
                    1:       k = `TLP_KEEP_LOW;
                    2:       k = `TLP_KEEP_FULL;
                    default: k = ($random(seed) & 1) ? `TLP_KEEP_FULL : `TLP_KEEP_LOW;
                endcase
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) @(posedge clk_sys);
                send_beat(d, k, i == len - 1);
                rx_valid <= 1'b0;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || stg_cnt != 0) && !aborted)
        begin
            @(negedge clk_sys);
            n++;
            if (n > DRAIN_LIMIT)
                note_timeout("tx output did not drain");
        end
    endtask

    task automatic wait_int_high();
        int n;
        n = 0;
        while (!int_assert && !aborted)
        begin
            @(negedge clk_sys);
            n++;
            if (n > INT_LIMIT)
                note_timeout("int_assert did not rise");
        end
    endtask

    // tx_mode 0 always ready, 1 random, 2 stalled
    always @(posedge clk_sys)
    begin
        case (tx_mode)
            0:       tx_ready <= 1'b1;
            1:       tx_ready <= ($random(seed) & 3) != 0;
            default: tx_ready <= 1'b0;
        endcase
        int_rdy <= int_mode ? (($random(seed) & 3) == 0) : 1'b0;
    end

    // --------------------------------------------------------------------------
    // monitor, sampled on the falling edge where all signals are settled
    // --------------------------------------------------------------------------

    always @(negedge clk_sys)
    begin
        beat64_t act;
        if (!rst)
        begin
            if (rx_valid && rx_ready)
            begin
                stg[stg_cnt] = rx_data[`TLP_DW_BITS-1:0];
                stg_cnt++;
                if (rx_keep[`TLP_DW_BITS/8])
                begin
                    stg[stg_cnt] = rx_data[2*`TLP_DW_BITS-1:`TLP_DW_BITS];
                    stg_cnt++;
                end
                if (stg_cnt > 2 || rx_last)
                begin
                    push_expected_beats(stg, stg_cnt, rx_last);
                    stg_cnt = 0;
                end
            end
            if (!rx_ready)
                saw_rx_stall = 1'b1;

            act.data = tx_data;
            act.keep = tx_keep;
            act.last = tx_last;
            // upper dword of a one-dword beat carries no data
            if (tx_keep != `TLP_KEEP_FULL)
                act.data[1] = '0;
            if (stall_q)
            begin
                check_bit("tx_valid", 1'b1, tx_valid);
                check_beat("tx held", held, act);
            end
            if (tx_valid)
                check_bit("tx_keep code", 1'b1,
                          tx_keep == `TLP_KEEP_FULL || tx_keep == `TLP_KEEP_LOW);
            if (tx_valid && tx_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    err_cnt++;
                    $display("tx beat at %0t with no received data left to match", $time);
                end
                else
                    check_beat("tx beat", exp_q.pop_front(), act);
            end
            stall_q = tx_valid && !tx_ready;
            held    = act;

            // grant, gap and re-request
            if (prev_int && !int_assert)
            begin
                check_bit("int_rdy", 1'b1, prev_rdy);
                grants++;
                in_gap  = 1'b1;
                low_cnt = 0;
            end
            if (in_gap && !int_assert)
                low_cnt++;
            if (in_gap && int_assert)
            begin
                in_gap = 1'b0;
                gaps++;
                if (low_cnt < `INT_HOLD_CYCLES)
                begin
                    err_cnt++;
                    $display("interrupt gap of %0d cycles at %0t is below the hold time",
                             low_cnt, $time);
                end
            end
            prev_int = int_assert;
            prev_rdy = int_rdy;
        end
    end

    // --------------------------------------------------------------------------
    // test sequence
    // --------------------------------------------------------------------------

    initial
    begin
        seed          = 32'ha7bbd26f;
        rst           = 1'b1;
        rx_data       = '0;
        rx_keep       = '0;
        rx_last       = 1'b0;
        rx_valid      = 1'b0;
        tx_ready      = 1'b1;
        int_rdy       = 1'b0;
        tx_mode       = 0;
        int_mode      = 1'b0;
        err_cnt       = 0;
        chk_cnt       = 0;
        test_cnt      = 0;
        test_err_base = 0;
        aborted       = 1'b0;
        stg_cnt       = 0;
        stall_q       = 1'b0;
        saw_rx_stall  = 1'b0;
        prev_int      = 1'b0;
        prev_rdy      = 1'b0;
        in_gap        = 1'b0;
        grants        = 0;
        gaps          = 0;

        // reset for three edges, outputs quiet throughout
        for (int i = 0; i < 3; i++)
        begin
            @(posedge clk_sys);
            if (i == 2)
                rst <= 1'b0;
            @(negedge clk_sys);
            check_bit("tx_valid", 1'b0, tx_valid);
            check_bit("int_assert", 1'b0, int_assert);
        end
        check_bit("rx_ready", 1'b1, rx_ready);
        // request goes up on the first cycle out of reset
        @(negedge clk_sys);
        check_bit("int_assert", 1'b1, int_assert);
        finish_test("reset");

        @(posedge clk_sys);
        run_packets(20, 0);
        wait_drain();
        finish_test("stream, tx always ready");

        tx_mode      = 1;
        saw_rx_stall = 1'b0;
        @(posedge clk_sys);
        fork
            begin
                repeat (10) @(posedge clk_sys);
                tx_mode = 2;
                repeat (80) @(posedge clk_sys);
                tx_mode = 1;
            end
            run_packets(24, 0);
        join
        wait_drain();
        check_bit("rx_ready low seen", 1'b1, saw_rx_stall);
        finish_test("stream, tx back-pressure");

        @(posedge clk_sys);
        run_packets(8, 1);
        run_packets(8, 2);
        wait_drain();
        finish_test("one-dword and two-dword packets");

        int_mode = 1'b1;
        begin
            int start;
            int n;
            start = grants;
            n     = 0;
            while (grants < start + 6 && !aborted)
            begin
                @(negedge clk_sys);
                n++;
                if (n > 6 * INT_LIMIT)
                    note_timeout("too few interrupt grants");
            end
        end
        int_mode = 1'b0;
        wait_int_high();
        // monitor counts the last rise on the same falling edge
        @(posedge clk_sys);
        if (!aborted && gaps != grants)
        begin
            err_cnt++;
            $display("interrupt gaps %0d do not match grants %0d", gaps, grants);
        end
        finish_test("interrupt pacing");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0 && !aborted)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
